//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// pc value carried by a bubble
`define NOP_PC 32'hffff_ffff

// addi x0, x0, 0
`define NOP_IR 32'h0000_0013

// data memory depth in words
`define DMEM_WORDS 64

`endif

//--- common.sv
`default_nettype none

package common;

typedef logic [31:0] word_t;     // data or address word
typedef logic [4:0]  regaddr_t;  // register index

typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA, SLT, SLTU,
    COPY2                        // result is op2, lui
} alu_mode_t;

typedef enum logic [1:0] {
    MA_X,                        // no memory access
    MA_LOAD,
    MA_STORE
} ma_mode_t;

typedef enum logic {
    MA_B,                        // byte, zero-extended on load
    MA_W
} ma_size_t;

typedef enum logic [1:0] {
    WB_SRC_NONE,
    WB_SRC_ALU,
    WB_SRC_MEM
} wb_src_t;

// major opcodes of the supported subset
typedef enum logic [6:0] {
    OPC_LOAD  = 7'b0000011,
    OPC_IMM   = 7'b0010011,
    OPC_STORE = 7'b0100011,
    OPC_REG   = 7'b0110011,
    OPC_LUI   = 7'b0110111
} opcode_t;

typedef struct packed {
    logic [6:0] funct7;
    regaddr_t   rs2;
    regaddr_t   rs1;
    logic [2:0] funct3;
    regaddr_t   rd;
    logic [6:0] opcode;
} r_fmt_t;

typedef struct packed {
    logic [11:0] imm12;
    regaddr_t    rs1;
    logic [2:0]  funct3;
    regaddr_t    rd;
    logic [6:0]  opcode;
} i_fmt_t;

typedef struct packed {
    logic [6:0] imm7;            // imm[11:5]
    regaddr_t   rs2;
    regaddr_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm5;            // imm[4:0]
    logic [6:0] opcode;
} s_fmt_t;

typedef struct packed {
    logic [19:0] imm20;
    regaddr_t    rd;
    logic [6:0]  opcode;
} u_fmt_t;

// one instruction word, four views
typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
} instr_u;

endpackage

`default_nettype wire

//--- ex_ma_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_ma_if
    import common::*;
    ();

word_t    pc;        // program counter
word_t    ir;        // instruction register
word_t    ma_addr;   // byte address, zero when no access
ma_mode_t ma_mode;
ma_size_t ma_size;
word_t    ma_data;   // store data
wb_src_t  wb_src;
word_t    wb_data;   // alu result or passed data
logic     wb_valid;

modport ex (output pc, ir, ma_addr, ma_mode, ma_size, ma_data, wb_src, wb_data, wb_valid);
modport ma (input  pc, ir, ma_addr, ma_mode, ma_size, ma_data, wb_src, wb_data, wb_valid);

endinterface

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import common::*;
    (
        input  wire alu_mode_t mode_i,    // operation select
        input  wire word_t     op1_i,
        input  wire word_t     op2_i,
        output word_t          result_o
    );

always_comb begin
    case (mode_i)
        ADD:     result_o = op1_i + op2_i;
        SUB:     result_o = op1_i - op2_i;
        AND:     result_o = op1_i & op2_i;
        OR:      result_o = op1_i | op2_i;
        XOR:     result_o = op1_i ^ op2_i;
        SLL:     result_o = op1_i << op2_i[4:0];   // shamt from low bits
        SRL:     result_o = op1_i >> op2_i[4:0];
        SRA:     result_o = word_t'($signed(op1_i) >>> op2_i[4:0]);
        SLT:     result_o = {31'b0, $signed(op1_i) < $signed(op2_i)};
        SLTU:    result_o = {31'b0, op1_i < op2_i};
        COPY2:   result_o = op2_i;                 // lui immediate
        default: result_o = '0;
    endcase
end

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
    import common::*;
    (
        input  wire logic     clk_i,
        input  wire logic     rst_n_i,
        input  wire regaddr_t rs1_i,
        input  wire regaddr_t rs2_i,
        output word_t         rd1_o,
        output word_t         rd2_o,
        input  wire logic     we_i,
        input  wire regaddr_t wa_i,
        input  wire word_t    wd_i
    );

word_t regs [1:31];   // x0 is not stored

function automatic word_t read_port(regaddr_t a);
    if (a == '0)
        return '0;
    if (we_i && a == wa_i)
        return wd_i;      // write-through
    return regs[a];
endfunction

always_comb begin
    rd1_o = read_port(rs1_i);
    rd2_o = read_port(rs2_i);
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        for (int i = 1; i < 32; i++)
            regs[i] <= '0;
    end else if (we_i && wa_i != '0) begin
        regs[wa_i] <= wd_i;
    end
end

endmodule

`default_nettype wire

//--- cpu_id.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu_id
    import common::*;
    (
        input  wire logic     clk_i,
        input  wire logic     rst_n_i,
        input  wire logic     instr_valid_i,   // feeder offers an instruction
        input  wire word_t    instr_i,
        input  wire word_t    pc_i,

        input  wire regaddr_t ex_wb_addr_i,    // forwarding from EX
        input  wire word_t    ex_wb_data_i,
        input  wire logic     ex_wb_ready_i,   // low for a load in EX
        input  wire logic     ex_wb_valid_i,
        input  wire regaddr_t ma_wb_addr_i,    // forwarding from MA
        input  wire word_t    ma_wb_data_i,
        input  wire logic     ma_wb_valid_i,
        input  wire logic     rf_we_i,         // retire write port
        input  wire regaddr_t rf_wa_i,
        input  wire word_t    rf_wd_i,

        output logic          stall_o,         // load-use hazard

        output word_t         pc_o,
        output word_t         ir_o,
        output word_t         alu_op1_o,
        output word_t         alu_op2_o,
        output alu_mode_t     alu_mode_o,
        output ma_mode_t      ma_mode_o,
        output ma_size_t      ma_size_o,
        output word_t         ma_data_o,
        output wb_src_t       wb_src_o,
        output word_t         wb_data_o,
        output logic          wb_valid_o
    );

instr_u    ir;
word_t     rf_rd1;
word_t     rf_rd2;
word_t     rs1_val;
word_t     rs2_val;
word_t     op1;
word_t     op2;
logic      rs1_used;
logic      rs2_used;
alu_mode_t alu_mode;
ma_mode_t  ma_mode;
ma_size_t  ma_size;
wb_src_t   wb_src;
logic      wb_valid;
word_t     imm_i;
word_t     imm_s;
word_t     imm_u;

assign ir = instr_i;

regfile regfile0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rs1_i   (ir.r_fmt.rs1),
    .rs2_i   (ir.r_fmt.rs2),
    .rd1_o   (rf_rd1),
    .rd2_o   (rf_rd2),
    .we_i    (rf_we_i),
    .wa_i    (rf_wa_i),
    .wd_i    (rf_wd_i)
);

assign imm_i = {{20{ir.i_fmt.imm12[11]}}, ir.i_fmt.imm12};
assign imm_s = {{20{ir.s_fmt.imm7[6]}}, ir.s_fmt.imm7, ir.s_fmt.imm5};
assign imm_u = {ir.u_fmt.imm20, 12'b0};

// funct3 to alu mode, alt picks sub / sra
function automatic alu_mode_t f3_mode(logic [2:0] f3, logic alt);
    case (f3)
        3'b000:  return alt ? SUB : ADD;
        3'b001:  return SLL;
        3'b010:  return SLT;
        3'b011:  return SLTU;
        3'b100:  return XOR;
        3'b101:  return alt ? SRA : SRL;
        3'b110:  return OR;
        default: return AND;
    endcase
endfunction

// priority EX, then MA, then regfile
function automatic word_t fwd(regaddr_t a, word_t rf_val);
    if (a == '0)
        return '0;
    if (ex_wb_valid_i && ex_wb_addr_i == a)
        return ex_wb_data_i;
    if (ma_wb_valid_i && ma_wb_addr_i == a)
        return ma_wb_data_i;
    return rf_val;
endfunction

always_comb begin
    rs1_val  = fwd(ir.r_fmt.rs1, rf_rd1);
    rs2_val  = fwd(ir.r_fmt.rs2, rf_rd2);
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    op1      = rs1_val;
    op2      = rs2_val;
    alu_mode = ADD;
    ma_mode  = MA_X;
    ma_size  = (ir.r_fmt.funct3 == 3'b010) ? MA_W : MA_B;   // lw/sw vs lbu/sb
    wb_src   = WB_SRC_NONE;
    wb_valid = 1'b0;
    case (ir.r_fmt.opcode)
        OPC_REG: begin
            rs1_used = 1'b1;
            rs2_used = 1'b1;
            alu_mode = f3_mode(ir.r_fmt.funct3, ir.r_fmt.funct7[5]);
            wb_src   = WB_SRC_ALU;
            wb_valid = 1'b1;
        end
        OPC_IMM: begin
            rs1_used = 1'b1;
            op2      = imm_i;
            alu_mode = f3_mode(ir.r_fmt.funct3,
                               ir.r_fmt.funct3 == 3'b101 && ir.r_fmt.funct7[5]);
            wb_src   = WB_SRC_ALU;
            wb_valid = 1'b1;
        end
        OPC_LUI: begin
            op1      = '0;
            op2      = imm_u;
            alu_mode = COPY2;
            wb_src   = WB_SRC_ALU;
            wb_valid = 1'b1;
        end
        OPC_LOAD: begin
            rs1_used = 1'b1;
            op2      = imm_i;           // address = rs1 + imm
            ma_mode  = MA_LOAD;
            wb_src   = WB_SRC_MEM;
            wb_valid = 1'b1;
        end
        OPC_STORE: begin
            rs1_used = 1'b1;
            rs2_used = 1'b1;            // store data
            op2      = imm_s;
            ma_mode  = MA_STORE;
        end
        default: ;                      // unsupported, no effect
    endcase
end

// EX load not yet ready and feeding a source
always_comb begin
    stall_o = instr_valid_i && ex_wb_valid_i && !ex_wb_ready_i && ex_wb_addr_i != '0
              && ((rs1_used && ir.r_fmt.rs1 == ex_wb_addr_i)
                  || (rs2_used && ir.r_fmt.rs2 == ex_wb_addr_i));
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i || !instr_valid_i || stall_o) begin   // issue a bubble
        pc_o       <= `NOP_PC;
        ir_o       <= `NOP_IR;
        alu_op1_o  <= '0;
        alu_op2_o  <= '0;
        alu_mode_o <= ADD;
        ma_mode_o  <= MA_X;
        ma_size_o  <= MA_W;
        ma_data_o  <= '0;
        wb_src_o   <= WB_SRC_NONE;
        wb_data_o  <= '0;
        wb_valid_o <= 1'b0;
    end else begin
        pc_o       <= pc_i;
        ir_o       <= instr_i;
        alu_op1_o  <= op1;
        alu_op2_o  <= op2;
        alu_mode_o <= alu_mode;
        ma_mode_o  <= ma_mode;
        ma_size_o  <= ma_size;
        ma_data_o  <= rs2_val;
        wb_src_o   <= wb_src;
        wb_data_o  <= '0;               // no non-alu source decoded here
        wb_valid_o <= wb_valid;
    end
end

endmodule

`default_nettype wire

//--- cpu_ex.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu_ex
    import common::*;
    (
        input  wire logic      clk_i,
        input  wire logic      rst_n_i,

        input  wire word_t     pc_i,
        input  wire word_t     ir_i,
        input  wire word_t     alu_op1_i,
        input  wire word_t     alu_op2_i,
        input  wire alu_mode_t alu_mode_i,
        input  wire ma_mode_t  ma_mode_i,
        input  wire ma_size_t  ma_size_i,
        input  wire word_t     ma_data_i,
        input  wire wb_src_t   wb_src_i,
        input  wire word_t     wb_data_i,
        input  wire logic      wb_valid_i,

        output regaddr_t       wb_addr_async_o,
        output word_t          wb_data_async_o,
        output logic           wb_ready_async_o,   // data known this cycle
        output logic           wb_valid_async_o,
        output logic           empty_async_o,      // bubble in EX

        ex_ma_if.ex            ex_ma_o
    );

word_t alu_result;

alu alu0 (
    .mode_i   (alu_mode_i),
    .op1_i    (alu_op1_i),
    .op2_i    (alu_op2_i),
    .result_o (alu_result)
);

always_comb begin
    wb_addr_async_o  = ir_i[11:7];
    wb_data_async_o  = (wb_src_i == WB_SRC_ALU) ? alu_result : wb_data_i;
    wb_ready_async_o = wb_src_i != WB_SRC_MEM;     // loads resolve in MA
    wb_valid_async_o = wb_valid_i;
    empty_async_o    = pc_i == `NOP_PC;
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        ex_ma_o.pc       <= `NOP_PC;
        ex_ma_o.ir       <= `NOP_IR;
        ex_ma_o.ma_addr  <= '0;
        ex_ma_o.ma_mode  <= MA_X;
        ex_ma_o.ma_size  <= MA_W;
        ex_ma_o.ma_data  <= '0;
        ex_ma_o.wb_src   <= WB_SRC_NONE;
        ex_ma_o.wb_data  <= '0;
        ex_ma_o.wb_valid <= 1'b0;
    end else begin
        ex_ma_o.pc       <= pc_i;
        ex_ma_o.ir       <= ir_i;
        ex_ma_o.ma_addr  <= (ma_mode_i == MA_X) ? '0 : alu_result;
        ex_ma_o.ma_mode  <= ma_mode_i;
        ex_ma_o.ma_size  <= ma_size_i;
        ex_ma_o.ma_data  <= ma_data_i;
        ex_ma_o.wb_src   <= wb_src_i;
        ex_ma_o.wb_data  <= wb_data_async_o;
        ex_ma_o.wb_valid <= wb_valid_i;
    end
end

endmodule

`default_nettype wire

//--- cpu_ma.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu_ma
    import common::*;
    (
        input  wire logic clk_i,
        input  wire logic rst_n_i,

        ex_ma_if.ma       ex_ma_i,

        output regaddr_t  wb_addr_async_o,
        output word_t     wb_data_async_o,   // load data resolved here
        output logic      wb_valid_async_o,

        output logic      retire_valid_o,
        output word_t     retire_pc_o,
        output logic      wb_valid_o,
        output regaddr_t  wb_addr_o,
        output word_t     wb_data_o
    );

word_t      mem [`DMEM_WORDS];
logic [5:0] idx;        // word index
logic [1:0] lane;       // byte lane
word_t      rdata;
word_t      load_val;

assign idx  = ex_ma_i.ma_addr[7:2];
assign lane = ex_ma_i.ma_addr[1:0];

always_comb begin
    rdata    = mem[idx];
    load_val = (ex_ma_i.ma_size == MA_W) ? rdata : {24'b0, rdata[{lane, 3'b000} +: 8]};
    wb_addr_async_o  = ex_ma_i.ir[11:7];
    wb_data_async_o  = (ex_ma_i.wb_src == WB_SRC_MEM) ? load_val : ex_ma_i.wb_data;
    wb_valid_async_o = ex_ma_i.wb_valid;
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        for (int i = 0; i < `DMEM_WORDS; i++)
            mem[i] <= '0;
    end else if (ex_ma_i.ma_mode == MA_STORE) begin
        if (ex_ma_i.ma_size == MA_W)
            mem[idx] <= ex_ma_i.ma_data;
        else
            mem[idx][{lane, 3'b000} +: 8] <= ex_ma_i.ma_data[7:0];   // sb, one lane
    end
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        retire_valid_o <= 1'b0;
        retire_pc_o    <= `NOP_PC;
        wb_valid_o     <= 1'b0;
        wb_addr_o      <= '0;
        wb_data_o      <= '0;
    end else begin
        retire_valid_o <= ex_ma_i.pc != `NOP_PC;   // every non-bubble
        retire_pc_o    <= ex_ma_i.pc;
        wb_valid_o     <= ex_ma_i.wb_valid;
        wb_addr_o      <= wb_addr_async_o;
        wb_data_o      <= wb_data_async_o;
    end
end

endmodule

`default_nettype wire

//--- cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
    import common::*;
    (
        input  wire logic     clk_i,
        input  wire logic     rst_n_i,
        input  wire logic     instr_valid_i,
        input  wire word_t    instr_i,
        input  wire word_t    pc_i,

        output wire logic     stall_o,         // feeder holds instruction
        output wire logic     retire_valid_o,
        output wire word_t    retire_pc_o,
        output wire logic     wb_valid_o,
        output wire regaddr_t wb_addr_o,
        output wire word_t    wb_data_o
    );

// ID to EX
word_t     id_pc;
word_t     id_ir;
word_t     id_alu_op1;
word_t     id_alu_op2;
alu_mode_t id_alu_mode;
ma_mode_t  id_ma_mode;
ma_size_t  id_ma_size;
word_t     id_ma_data;
wb_src_t   id_wb_src;
word_t     id_wb_data;
logic      id_wb_valid;

// forwarding paths
regaddr_t  ex_wb_addr;
word_t     ex_wb_data;
logic      ex_wb_ready;
logic      ex_wb_valid;
regaddr_t  ma_wb_addr;
word_t     ma_wb_data;
logic      ma_wb_valid;

ex_ma_if ex_ma ();

cpu_id cpu_id0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .ex_wb_addr_i  (ex_wb_addr),
    .ex_wb_data_i  (ex_wb_data),
    .ex_wb_ready_i (ex_wb_ready),
    .ex_wb_valid_i (ex_wb_valid),
    .ma_wb_addr_i  (ma_wb_addr),
    .ma_wb_data_i  (ma_wb_data),
    .ma_wb_valid_i (ma_wb_valid),
    .rf_we_i       (wb_valid_o),       // retire writes the regfile
    .rf_wa_i       (wb_addr_o),
    .rf_wd_i       (wb_data_o),
    .stall_o       (stall_o),
    .pc_o          (id_pc),
    .ir_o          (id_ir),
    .alu_op1_o     (id_alu_op1),
    .alu_op2_o     (id_alu_op2),
    .alu_mode_o    (id_alu_mode),
    .ma_mode_o     (id_ma_mode),
    .ma_size_o     (id_ma_size),
    .ma_data_o     (id_ma_data),
    .wb_src_o      (id_wb_src),
    .wb_data_o     (id_wb_data),
    .wb_valid_o    (id_wb_valid)
);

cpu_ex cpu_ex0 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .pc_i             (id_pc),
    .ir_i             (id_ir),
    .alu_op1_i        (id_alu_op1),
    .alu_op2_i        (id_alu_op2),
    .alu_mode_i       (id_alu_mode),
    .ma_mode_i        (id_ma_mode),
    .ma_size_i        (id_ma_size),
    .ma_data_i        (id_ma_data),
    .wb_src_i         (id_wb_src),
    .wb_data_i        (id_wb_data),
    .wb_valid_i       (id_wb_valid),
    .wb_addr_async_o  (ex_wb_addr),
    .wb_data_async_o  (ex_wb_data),
    .wb_ready_async_o (ex_wb_ready),
    .wb_valid_async_o (ex_wb_valid),
    .empty_async_o    (),              // debug only
    .ex_ma_o          (ex_ma.ex)
);

cpu_ma cpu_ma0 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ex_ma_i          (ex_ma.ma),
    .wb_addr_async_o  (ma_wb_addr),
    .wb_data_async_o  (ma_wb_data),
    .wb_valid_async_o (ma_wb_valid),
    .retire_valid_o   (retire_valid_o),
    .retire_pc_o      (retire_pc_o),
    .wb_valid_o       (wb_valid_o),
    .wb_addr_o        (wb_addr_o),
    .wb_data_o        (wb_data_o)
);

endmodule

`default_nettype wire

//--- tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module tb_cpu_core
    import common::*;
    ();

typedef struct packed {
    word_t       pc;
    logic        wb_valid;
    regaddr_t    rd;
    word_t       data;
    logic [31:0] retire_edge;   // edge after which it must retire
} expect_t;

logic     clk_i;
logic     rst_n_i;
logic     instr_valid_i;
word_t    instr_i;
word_t    pc_i;
logic     stall_o;
logic     retire_valid_o;
word_t    retire_pc_o;
logic     wb_valid_o;
regaddr_t wb_addr_o;
word_t    wb_data_o;

word_t       model_regs [32];
word_t       model_mem [`DMEM_WORDS];
expect_t     exp_q [$];
word_t       lcg_state = 32'hdded8e97;
int unsigned edge_cnt = 0;
int          stall_cnt;

cpu_core dut0 (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .stall_o        (stall_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .wb_valid_o     (wb_valid_o),
    .wb_addr_o      (wb_addr_o),
    .wb_data_o      (wb_data_o)
);

initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
end

always @(posedge clk_i) edge_cnt <= edge_cnt + 1;   // index of the latest edge

task automatic stop_run();
    $display("Test failed");
    $fatal(1);
endtask

task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    stop_run();
endtask

task automatic check_word(input word_t got, input word_t exp, input string name);
    if (got !== exp) begin
        $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        stop_run();
    end
endtask

task automatic check_regaddr(input regaddr_t got, input regaddr_t exp, input string name);
    if (got !== exp) begin
        $display("mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        stop_run();
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
        $display("mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        stop_run();
    end
endtask

// upper state bits have the longer periods
function automatic word_t rnd();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
endfunction

// RV32I integer op selected by funct3
function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << sh;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> sh) : a >> sh;
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic expect_t ref_exec(instr_u w, word_t pc);
    expect_t    e;
    word_t      a;
    word_t      b;
    word_t      addr;
    logic [2:0] f3;
    logic [5:0] wi;
    logic [1:0] ln;
    e    = '0;
    e.pc = pc;
    f3   = w.r_fmt.funct3;
    a    = (w.r_fmt.rs1 == '0) ? '0 : model_regs[w.r_fmt.rs1];
    b    = (w.r_fmt.rs2 == '0) ? '0 : model_regs[w.r_fmt.rs2];
    addr = '0;
    case (w.r_fmt.opcode)
        OPC_REG: begin
            e.wb_valid = 1'b1;
            e.data     = alu_ref(f3, w.r_fmt.funct7[5], a, b);
        end
        OPC_IMM: begin
            e.wb_valid = 1'b1;
            e.data     = alu_ref(f3, f3 == 3'b101 && w.r_fmt.funct7[5], a,
                                 {{20{w.i_fmt.imm12[11]}}, w.i_fmt.imm12});
        end
        OPC_LUI: begin
            e.wb_valid = 1'b1;
            e.data     = {w.u_fmt.imm20, 12'h000};
        end
        OPC_LOAD: begin
            addr       = a + {{20{w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
            wi         = addr[7:2];
            ln         = addr[1:0];
            e.wb_valid = 1'b1;
            e.data     = (f3 == 3'b010) ? model_mem[wi] : {24'h0, model_mem[wi][8*ln +: 8]};
        end
        OPC_STORE: begin
            addr = a + {{20{w.s_fmt.imm7[6]}}, w.s_fmt.imm7, w.s_fmt.imm5};
            wi   = addr[7:2];
            ln   = addr[1:0];
            if (f3 == 3'b010)
                model_mem[wi] = b;
            else
                model_mem[wi][8*ln +: 8] = b[7:0];   // one byte lane
        end
        default: ;
    endcase
    if (e.wb_valid) begin
        e.rd = w.r_fmt.rd;
        if (e.rd != '0)
            model_regs[e.rd] = e.data;   // x0 stays zero
    end
    return e;
endfunction

// true when w reads register r as a source
function automatic logic reads_reg(instr_u w, regaddr_t r);
    logic s1;
    logic s2;
    s1 = 1'b0;
    s2 = 1'b0;
    case (w.r_fmt.opcode)
        OPC_REG, OPC_STORE: begin
            s1 = 1'b1;
            s2 = 1'b1;
        end
        OPC_IMM, OPC_LOAD: s1 = 1'b1;
        default: ;
    endcase
    return r != '0 && ((s1 && w.r_fmt.rs1 == r) || (s2 && w.r_fmt.rs2 == r));
endfunction

// registers x0..x7 and memory ops based on x0
function automatic instr_u gen_instr();
    instr_u     w;
    word_t      r;
    word_t      s;
    logic [3:0] kind;
    logic [2:0] f3;
    logic [7:0] addr;
    r    = rnd();
    s    = rnd();            // immediates
    kind = r[3:0];
    f3   = r[6:4];
    addr = s[7:0];
    w    = '0;
    if (kind < 5) begin
        w.r_fmt.opcode = OPC_REG;
        w.r_fmt.funct3 = f3;
        w.r_fmt.funct7 = (r[16] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
        w.r_fmt.rd     = r[9:7];
        w.r_fmt.rs1    = r[12:10];
        w.r_fmt.rs2    = r[15:13];
    end else if (kind < 9) begin
        w.i_fmt.opcode = OPC_IMM;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = r[9:7];
        w.i_fmt.rs1    = r[12:10];
        if (f3 == 3'b001)
            w.i_fmt.imm12 = {7'b0, s[4:0]};
        else if (f3 == 3'b101)
            w.i_fmt.imm12 = {(r[16] ? 7'b0100000 : 7'b0), s[4:0]};   // srai or srli
        else
            w.i_fmt.imm12 = s[11:0];
    end else if (kind == 9) begin
        w.u_fmt.opcode = OPC_LUI;
        w.u_fmt.rd     = r[9:7];
        w.u_fmt.imm20  = s[19:0];
    end else if (kind < 13) begin
        w.i_fmt.opcode = OPC_LOAD;
        w.i_fmt.funct3 = r[16] ? 3'b010 : 3'b100;   // lw or lbu
        w.i_fmt.rd     = r[9:7];
        if (r[16])
            addr[1:0] = 2'b00;
        w.i_fmt.imm12  = {4'b0, addr};
    end else begin
        w.s_fmt.opcode = OPC_STORE;
        w.s_fmt.funct3 = r[16] ? 3'b010 : 3'b000;   // sw or sb
        w.s_fmt.rs2    = r[15:13];
        if (r[16])
            addr[1:0] = 2'b00;
        w.s_fmt.imm7   = {4'b0, addr[7:5]};
        w.s_fmt.imm5   = addr[4:0];
    end
    return w;
endfunction

initial begin : stimulus
    instr_u      w;
    expect_t     e;
    word_t       pc;
    word_t       g;
    int          waited;
    logic        exp_stall;
    logic [31:0] prev_edge;
    logic        prev_load;
    regaddr_t    prev_rd;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = `NOP_IR;
    pc_i          = '0;
    pc            = 32'h0000_0100;
    prev_edge     = '0;
    prev_load     = 1'b0;
    prev_rd       = '0;
    stall_cnt     = 0;
    for (int i = 0; i < 32; i++)
        model_regs[i] = '0;
    for (int i = 0; i < `DMEM_WORDS; i++)
        model_mem[i] = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (3) begin               // idle pipeline after reset
        @(negedge clk_i);
        check_bit(stall_o, 1'b0, "stall_o");
        check_bit(retire_valid_o, 1'b0, "retire_valid_o");
        check_bit(wb_valid_o, 1'b0, "wb_valid_o");
    end
    @(posedge clk_i);
    for (int n = 0; n < 300; n++) begin
        w = gen_instr();
        instr_valid_i <= 1'b1;
        instr_i       <= w;
        pc_i          <= pc;
        // load accepted on this very edge sits in EX next cycle
        exp_stall = prev_load && prev_edge == edge_cnt + 1 && reads_reg(w, prev_rd);
        waited = 0;
        do begin
            @(posedge clk_i);
            check_bit(stall_o, waited == 0 && exp_stall, "stall_o");
            waited++;
            if (waited > 8)
                report_failure("instruction never accepted while stall_o stayed high");
        end while (stall_o);
        if (exp_stall)
            stall_cnt++;
        e = ref_exec(w, pc);
        e.retire_edge = edge_cnt + 3;   // accepting edge plus two
        exp_q.push_back(e);
        prev_edge = edge_cnt + 1;
        prev_load = w.r_fmt.opcode == OPC_LOAD;
        prev_rd   = w.r_fmt.rd;
        pc        = pc + 4;
        g = rnd();
        if (g[3:0] < 4) begin          // idle gap
            instr_valid_i <= 1'b0;
            repeat (int'(g[5:4]) + 1) @(posedge clk_i);
        end
    end
    instr_valid_i <= 1'b0;
    waited = 0;
    while (exp_q.size() != 0) begin
        @(posedge clk_i);
        waited++;
        if (waited > 20)
            report_failure("pipeline did not drain after the last instruction");
    end
    if (stall_cnt == 0) begin
        report_failure("no load-use stall occurred in the program");
    end else begin
        $display("Test passed");
        $finish;
    end
end

initial begin : compare_retires
    expect_t e;
    int      idle;
    idle = 0;
    forever begin
        @(negedge clk_i);
        if (rst_n_i) begin
            if (retire_valid_o) begin
                if (exp_q.size() == 0)
                    report_failure("retire seen with no instruction in flight");
                e = exp_q.pop_front();
                idle = 0;
                check_word(retire_pc_o, e.pc, "retire_pc_o");
                check_bit(wb_valid_o, e.wb_valid, "wb_valid_o");
                if (e.wb_valid) begin
                    check_regaddr(wb_addr_o, e.rd, "wb_addr_o");
                    check_word(wb_data_o, e.data, "wb_data_o");
                end
                if (edge_cnt != e.retire_edge)
                    report_failure($sformatf("pc %h retired at edge %0d instead of %0d",
                                             e.pc, edge_cnt, e.retire_edge));
            end else begin
                check_bit(wb_valid_o, 1'b0, "wb_valid_o");   // bubble
                if (exp_q.size() != 0)
                    idle++;
                if (idle > 50)
                    report_failure("no retire for 50 cycles with instructions in flight");
            end
        end
    end
end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
common.sv
ex_ma_if.sv
alu.sv
regfile.sv
cpu_id.sv
cpu_ex.sv
cpu_ma.sv
cpu_core.sv
tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - common.sv
      - ex_ma_if.sv
      - alu.sv
      - regfile.sv
      - cpu_id.sv
      - cpu_ex.sv
      - cpu_ma.sv
      - cpu_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cpu_core.sv
